// File: all.f
+incdir+src
src/dcache_addr_pkg.sv
src/dcache_bus_pkg.sv
src/dcache_req_check.sv
src/dcache_miss_fsm.sv
src/dcache_recover_timer.sv
src/dcache_store_buffers.sv
src/dcache_data_path.sv
src/dcache_hit_stage.sv
testbench/tb_dcache_hit_stage.sv

// File: Bender.yml
package:
  name: dcache_hit_stage

export_include_dirs:
  - src

sources:
  - src/dcache_addr_pkg.sv
  - src/dcache_bus_pkg.sv
  - src/dcache_req_check.sv
  - src/dcache_miss_fsm.sv
  - src/dcache_recover_timer.sv
  - src/dcache_store_buffers.sv
  - src/dcache_data_path.sv
  - src/dcache_hit_stage.sv
  - target: test
    files:
      - testbench/tb_dcache_hit_stage.sv

// File: testbench/dcache_cases.txt
// kind addr data be line hit dirty exp_q, all hex
// kind 01 load, 02 store then load, 03 misaligned, 04 access fault, 05 pagefault, 00 end
01 00a00c18 00000000 0 deadbeefcafef00d0123456789abcdef 1 0 cafef00d
01 7f0012bc 00000000 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 1 0 0f1e2d3c
02 10002034 a1b2c3d4 3 deadbeefcafef00d0123456789abcdef 1 0 0123c3d4
01 00abc0d4 600dcafe 0 deadbeefcafef00d0123456789abcdef 0 0 600dcafe
01 00000040 00000000 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 1 0 c3d2e1f0
01 0badf0e8 feedface 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 1 feedface
02 20003058 55aa66bb c 0f1e2d3c4b5a69788796a5b4c3d2e1f0 1 0 55aa6978
03 00001001 00000000 0 00000000000000000000000000000000 0 0 00000000
02 3000400c 13579bdf f deadbeefcafef00d0123456789abcdef 1 0 13579bdf
01 12340000 0000abcd 0 deadbeefcafef00d0123456789abcdef 0 0 0000abcd
04 00002000 00000000 0 00000000000000000000000000000000 0 0 00000000
02 00000070 11223344 9 0f1e2d3c4b5a69788796a5b4c3d2e1f0 1 0 11d2e144
01 5555555c 87654321 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 1 87654321
05 00003000 00000000 0 00000000000000000000000000000000 0 0 00000000
01 00a00c14 00000000 0 deadbeefcafef00d0123456789abcdef 1 0 01234567
01 abcdef08 5a5aa5a5 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 1 5a5aa5a5
01 abcdef08 00000000 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0 1 0 4b5a6978
00 00000000 00000000 0 00000000000000000000000000000000 0 0 00000000

// File: testbench/tb_dcache_hit_stage.sv
// Testbench for the data cache hit stage.
// Reads its cases from testbench/dcache_cases.txt, drives the DUT on the
// falling clock edge and plays memory, bus interface and write port.

`timescale 1ns/1ns

`include "dcache_settings.svh"

`default_nettype none

module tb_dcache_hit_stage
  import dcache_addr_pkg::*, dcache_bus_pkg::*;
();

  localparam int CLK_HALF   = 20;
  localparam int WAIT_LIMIT = 50;
  localparam int MAX_CASES  = 64;
  localparam int COLS       = 8;

  logic       clk_i;
  logic       rst_ni;
  core_req_s  req;
  core_exc_s  exc;
  logic       flush;
  mem_rsp_s   mem;
  evict_in_s  evict_in;
  biu_rsp_s   biu;
  logic       biucmd_ack;
  logic       biucmd_busy;
  logic       writebuffer_ack;

  logic       stall;
  logic       latchmem;
  biucmd_e    biucmd;
  ways_t      fill_way;
  logic       filling;
  wbuf_s      wbuf;
  evict_buf_s evict_buf;
  logic       ack;
  word_t      q;
  logic       err;
  logic       misaligned;
  logic       pagefault;
  idx_t       idx;
  tag_t       core_tag;

  logic [127:0] case_mem [0:COLS*MAX_CASES-1];
  integer       seed;
  int           errors;
  int           timeouts;
  int           cases_run;
  int           c;
  logic         done;
  logic [7:0]   kind;
  logic [31:0]  addr;
  word_t        data;
  be_t          be;
  line_t        line;
  logic         hit;
  logic         dirty;
  word_t        exp_q;

  dcache_hit_stage dut (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req), .exc_i(exc), .flush_i(flush),
    .mem_i(mem), .evict_i(evict_in), .biu_i(biu), .biucmd_ack_i(biucmd_ack),
    .biucmd_busy_i(biucmd_busy), .writebuffer_ack_i(writebuffer_ack),
    .stall_o(stall), .latchmem_o(latchmem), .biucmd_o(biucmd), .fill_way_o(fill_way),
    .filling_o(filling), .wbuf_o(wbuf), .evict_o(evict_buf), .ack_o(ack), .q_o(q),
    .err_o(err), .misaligned_o(misaligned), .pagefault_o(pagefault), .idx_o(idx),
    .core_tag_o(core_tag)
  );

  always #CLK_HALF clk_i = ~clk_i;

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s at %0t ns", what, $time);
    timeouts++;
  endtask

  task automatic drive_idle();
    req        = '0;
    exc        = '0;
    mem        = '0;
    evict_in   = '0;
    biu        = '0;
    biucmd_ack = 1'b0;
  endtask

  task automatic drive_request(input logic wreq, input logic [31:0] a_flat, input word_t d,
                               input be_t b, input line_t l, input logic h, input logic dt);
    dcache_adr_u a;
    a.flat         = a_flat;
    req.req        = 1'b1;
    req.wreq       = wreq;
    req.adr        = a;
    req.be         = b;
    req.d          = d;
    mem.hit        = h;
    mem.ways_hit   = h ? ways_t'(1) : ways_t'(0);
    mem.line       = l;
    mem.way_dirty  = dt;
    mem.fill_way   = ways_t'(2);
    // victim sits in the same set under another tag
    evict_in.idx   = a.f.idx;
    evict_in.tag   = ~a.f.tag;
    evict_in.line  = l;
  endtask

  ////////////////////
  // case runners
  ////////////////////

  task automatic run_load_hit(input logic [31:0] a_flat, input line_t l, input word_t eq);
    @(negedge clk_i);
    drive_request(1'b0, a_flat, '0, '1, l, 1'b1, 1'b0);
    #1;
    check_value("stall_o", stall, 1'b0);
    // set index sits just above the word and byte offsets
    check_value("idx_o", idx, a_flat[`DCACHE_IDX_BITS+3:4]);
    check_value("core_tag_o", core_tag, a_flat[31:`DCACHE_IDX_BITS+4]);
    @(negedge clk_i);
    check_value("ack_o", ack, 1'b1);
    check_value("q_o", q, eq);
    drive_idle();
  endtask

  task automatic run_store(input logic [31:0] a_flat, input word_t d, input be_t b,
                           input line_t l, input word_t eq);
    dcache_adr_u a;
    line_be_t    exp_be;
    int          n;
    a.flat = a_flat;
    // word enables land on the byte lanes of the addressed word
    exp_be = line_be_t'(b) << (int'(a.f.dat_offs) * (`DCACHE_XLEN / 8));
    @(negedge clk_i);
    drive_request(1'b1, a_flat, d, b, l, 1'b1, 1'b0);
    @(negedge clk_i);
    check_value("wbuf_o.we", wbuf.we, 1'b1);
    check_value("wbuf_o.idx", wbuf.idx, a.f.idx);
    check_value("wbuf_o.offs", wbuf.offs, a.f.dat_offs);
    check_value("wbuf_o.data", wbuf.data, d);
    check_value("wbuf_o.be", wbuf.be, exp_be);
    check_value("wbuf_o.ways_hit", wbuf.ways_hit, ways_t'(1));
    // same word read back while the store still waits
    drive_request(1'b0, a_flat, '0, '1, l, 1'b1, 1'b0);
    @(negedge clk_i);
    check_value("ack_o", ack, 1'b1);
    check_value("q_o", q, eq);
    check_value("wbuf_o.we", wbuf.we, 1'b1);
    drive_idle();
    writebuffer_ack = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (wbuf.we !== 1'b0 && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    writebuffer_ack = 1'b0;
    if (wbuf.we !== 1'b0) report_timeout("write buffer to drain");
  endtask

  task automatic run_miss(input logic [31:0] a_flat, input word_t d, input line_t l,
                          input logic dt, input word_t eq);
    dcache_adr_u a;
    dcache_adr_u exp_adr;
    int          n;
    int          i;
    int          delay;
    int          reads;
    int          writes;
    int          stall_cycles;
    int          latch_high;
    logic        latch_last;
    a.flat             = a_flat;
    exp_adr.f.tag      = ~a.f.tag;
    exp_adr.f.idx      = a.f.idx;
    exp_adr.f.dat_offs = '0;
    exp_adr.f.byte_offs = '0;
    writes       = 0;
    stall_cycles = 0;
    latch_high   = 0;
    latch_last   = 1'b0;
    @(negedge clk_i);
    drive_request(1'b0, a_flat, '0, '1, l, 1'b0, dt);
    #1;
    check_value("stall_o", stall, 1'b1);
    n = 0;
    @(negedge clk_i);
    while (biucmd !== READWAY && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (biucmd !== READWAY) begin
      report_timeout("READWAY command");
      drive_idle();
      return;
    end
    reads = 1;
    check_value("filling_o", filling, 1'b1);
    check_value("fill_way_o", fill_way, ways_t'(2));
    if (dt) begin
      check_value("evict_o.adr", evict_buf.adr.flat, exp_adr.flat);
      check_value("evict_o.line", evict_buf.line, l);
    end
    // bus answers after a random number of cycles
    delay = ($random(seed) & 3) + 1;
    for (i = 0; i < delay; i++) begin
      @(negedge clk_i);
      if (biucmd === READWAY) reads++;
      check_value("stall_o", stall, 1'b1);
    end
    biu.q      = d;
    biu.adro   = a_flat;
    biu.ack    = 1'b1;
    biucmd_ack = 1'b1;
    @(negedge clk_i);
    check_value("ack_o", ack, 1'b1);
    check_value("q_o", q, eq);
    // recover window starts the cycle after the bus ack
    n = 0;
    while (stall !== 1'b0 && n < WAIT_LIMIT) begin
      stall_cycles++;
      if (latchmem === 1'b1) latch_high++;
      latch_last = latchmem;
      if (biucmd === READWAY) reads++;
      if (biucmd === WRITEWAY) writes++;
      drive_idle();
      @(negedge clk_i);
      n++;
    end
    drive_idle();
    if (stall !== 1'b0) begin
      report_timeout("end of recover");
      return;
    end
    check_value("recover cycles", stall_cycles, `DCACHE_RECOVER_CYCLES);
    check_value("latchmem_o high cycles", latch_high, 1);
    check_value("latchmem_o on last recover cycle", latch_last, 1'b1);
    check_value("READWAY count", reads, 1);
    check_value("WRITEWAY count", writes, dt ? 1 : 0);
  endtask

  task automatic run_exception(input logic [7:0] k, input logic [31:0] a_flat);
    @(negedge clk_i);
    drive_request(1'b0, a_flat, '0, '1, '0, 1'b0, 1'b0);
    exc.misaligned   = (k == 8'h03);
    exc.access_fault = (k == 8'h04);
    exc.pagefault    = (k == 8'h05);
    @(negedge clk_i);
    check_value("misaligned_o", misaligned, k == 8'h03);
    check_value("err_o", err, k == 8'h04);
    check_value("pagefault_o", pagefault, k == 8'h05);
    check_value("ack_o", ack, 1'b0);
    drive_idle();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    seed            = 32'hceaaec69;
    errors          = 0;
    timeouts        = 0;
    cases_run       = 0;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    flush           = 1'b0;
    biucmd_busy     = 1'b0;
    writebuffer_ack = 1'b0;
    drive_idle();
    $readmemh("testbench/dcache_cases.txt", case_mem);
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    check_value("biucmd_o", biucmd, NOP);
    check_value("ack_o", ack, 1'b0);
    check_value("filling_o", filling, 1'b0);
    check_value("wbuf_o.we", wbuf.we, 1'b0);
    check_value("armed", dut.armed, 1'b1);
    rst_ni = 1'b1;

    c    = 0;
    done = 1'b0;
    while (!done && c < MAX_CASES && timeouts == 0) begin
      kind  = case_mem[COLS*c][7:0];
      addr  = case_mem[COLS*c+1][31:0];
      data  = case_mem[COLS*c+2][31:0];
      be    = case_mem[COLS*c+3][3:0];
      line  = case_mem[COLS*c+4];
      hit   = case_mem[COLS*c+5][0];
      dirty = case_mem[COLS*c+6][0];
      exp_q = case_mem[COLS*c+7][31:0];
      case (kind)
        8'h01: begin
          if (hit) run_load_hit(addr, line, exp_q);
          else run_miss(addr, data, line, dirty, exp_q);
        end
        8'h02: run_store(addr, data, be, line, exp_q);
        8'h03, 8'h04, 8'h05: run_exception(kind, addr);
        default: begin
          if (kind !== 8'h00) begin
            $display("unknown case kind 0x%0h in case %0d", kind, c);
            errors++;
          end
          done = 1'b1;
        end
      endcase
      if (!done) cases_run++;
      c++;
    end
    if (cases_run == 0) begin
      $display("no cases were read from the case file");
      errors++;
    end

    @(negedge clk_i);
    $display("errors: %0d, timeouts: %0d, cases run: %0d", errors, timeouts, cases_run);
    if (errors == 0 && timeouts == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/dcache_hit_stage.sv
// Top level of the data cache hit stage.
// Connects request checking, the miss FSM, the recover timer, the store
// buffers and the read data path.

`timescale 1ns/1ns

`default_nettype none

module dcache_hit_stage
  import dcache_addr_pkg::*, dcache_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  core_req_s  req_i,
  input  core_exc_s  exc_i,
  input  logic       flush_i,
  input  mem_rsp_s   mem_i,
  input  evict_in_s  evict_i,
  input  biu_rsp_s   biu_i,
  input  logic       biucmd_ack_i,
  input  logic       biucmd_busy_i,
  input  logic       writebuffer_ack_i,
  output logic       stall_o,
  output logic       latchmem_o,
  output biucmd_e    biucmd_o,
  output ways_t      fill_way_o,
  output logic       filling_o,
  output wbuf_s      wbuf_o,
  output evict_buf_s evict_o,
  output logic       ack_o,
  output word_t      q_o,
  output logic       err_o,
  output logic       misaligned_o,
  output logic       pagefault_o,
  output idx_t       idx_o,
  output tag_t       core_tag_o
);

  logic live;
  logic served;
  logic armed;
  logic recover_start;
  logic recover_last;

  // set index and tag for memory writes
  assign idx_o      = req_i.adr.f.idx;
  assign core_tag_o = req_i.adr.f.tag;

  dcache_req_check u_req_check (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .exc_i(exc_i), .flush_i(flush_i),
    .biu_err_i(biu_i.err), .live_o(live), .err_o(err_o), .misaligned_o(misaligned_o),
    .pagefault_o(pagefault_o)
  );

  dcache_miss_fsm u_miss_fsm (
    .clk_i(clk_i), .rst_ni(rst_ni), .live_i(live), .served_i(served),
    .way_dirty_i(mem_i.way_dirty), .fill_way_i(mem_i.fill_way),
    .biucmd_ack_i(biucmd_ack_i), .biucmd_busy_i(biucmd_busy_i), .biu_err_i(biu_i.err),
    .recover_last_i(recover_last), .recover_start_o(recover_start), .biucmd_o(biucmd_o),
    .armed_o(armed), .filling_o(filling_o), .fill_way_o(fill_way_o), .stall_o(stall_o),
    .latchmem_o(latchmem_o)
  );

  dcache_recover_timer u_recover_timer (
    .clk_i(clk_i), .rst_ni(rst_ni), .start_i(recover_start), .last_o(recover_last)
  );

  dcache_store_buffers u_store_buffers (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .live_i(live), .hit_i(mem_i.hit),
    .ways_hit_i(mem_i.ways_hit), .flush_i(flush_i), .writebuffer_ack_i(writebuffer_ack_i),
    .armed_i(armed), .evict_i(evict_i), .wbuf_o(wbuf_o), .evict_o(evict_o)
  );

  dcache_data_path u_data_path (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .live_i(live), .armed_i(armed),
    .filling_i(filling_o), .mem_i(mem_i), .biu_i(biu_i), .wbuf_i(wbuf_o),
    .served_o(served), .ack_o(ack_o), .q_o(q_o)
  );

endmodule

`default_nettype wire

// File: src/dcache_data_path.sv
// Read data path of the hit stage.
// Merges a pending store over the cache line, selects the requested
// word, and answers either from the cache or from the fill data.

`timescale 1ns/1ns

`include "dcache_settings.svh"

`default_nettype none

module dcache_data_path
  import dcache_addr_pkg::*, dcache_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_req_s req_i,
  input  logic      live_i,
  input  logic      armed_i,
  input  logic      filling_i,
  input  mem_rsp_s  mem_i,
  input  biu_rsp_s  biu_i,
  input  wbuf_s     wbuf_i,
  output logic      served_o,
  output logic      ack_o,
  output word_t     q_o
);

  localparam int LINE_BYTES = `DCACHE_LINE_BITS / 8;
  localparam int WORDS      = `DCACHE_LINE_BITS / `DCACHE_XLEN;

  logic        bypass;
  line_t       wbuf_line;
  line_t       merged_line;
  word_t       cache_q;
  dcache_adr_u biu_adr;
  logic        biu_adr_match;

  // write buffer bypass, same set still pending
  assign bypass    = wbuf_i.we & (wbuf_i.idx == req_i.adr.f.idx);
  assign wbuf_line = {WORDS{wbuf_i.data}};

  always_comb begin
    for (int i = 0; i < LINE_BYTES; i++) begin
      merged_line[i*8 +: 8] = (bypass & wbuf_i.be[i]) ? wbuf_line[i*8 +: 8]
                                                      : mem_i.line[i*8 +: 8];
    end
  end

  assign cache_q = merged_line[req_i.adr.f.dat_offs * `DCACHE_XLEN +: `DCACHE_XLEN];

  // fill beat carries the requested word
  assign biu_adr       = biu_i.adro;
  assign biu_adr_match = (biu_adr.f.tag == req_i.adr.f.tag) &
                         (biu_adr.f.idx == req_i.adr.f.idx) &
                         (biu_adr.f.dat_offs == req_i.adr.f.dat_offs);

  always_comb begin
    if (armed_i) served_o = live_i & mem_i.hit;
    else if (filling_i) served_o = live_i & (mem_i.hit | (biu_i.ack & biu_adr_match));
    else served_o = 1'b0;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) ack_o <= 1'b0;
    else ack_o <= served_o;
  end

  always_ff @(posedge clk_i) begin
    q_o <= (filling_i & ~mem_i.hit) ? biu_i.q : cache_q;
  end

endmodule

`default_nettype wire

// File: src/dcache_store_buffers.sv
// Write buffer and evict buffer of the hit stage.
// A store hit is parked in the write buffer until the data memory takes
// it. The victim address and line are held so the memories can move on
// while a miss is served.

`timescale 1ns/1ns

`include "dcache_settings.svh"

`default_nettype none

module dcache_store_buffers
  import dcache_addr_pkg::*, dcache_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  core_req_s  req_i,
  input  logic       live_i,
  input  logic       hit_i,
  input  ways_t      ways_hit_i,
  input  logic       flush_i,
  input  logic       writebuffer_ack_i,
  input  logic       armed_i,
  input  evict_in_s  evict_i,
  output wbuf_s      wbuf_o,
  output evict_buf_s evict_o
);

  localparam int BE_PER_WORD = `DCACHE_XLEN / 8;

  logic        store_hit;
  logic        we_q;
  idx_t        idx_q;
  dat_offs_t   offs_q;
  word_t       data_q;
  line_be_t    be_q;
  ways_t       ways_hit_q;
  dcache_adr_u evict_adr_q;
  line_t       evict_line_q;

  assign store_hit = live_i & req_i.wreq & hit_i;

  ////////////////////
  // write buffer
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) we_q <= 1'b0;
    else if (flush_i) we_q <= 1'b0;
    else if (store_hit) we_q <= 1'b1;
    else if (writebuffer_ack_i) we_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (store_hit) begin
      idx_q      <= req_i.adr.f.idx;
      offs_q     <= req_i.adr.f.dat_offs;
      data_q     <= req_i.d;
      // move word enables to their byte lanes in the line
      be_q       <= line_be_t'(req_i.be) << (req_i.adr.f.dat_offs * BE_PER_WORD);
      ways_hit_q <= ways_hit_i;
    end
  end

  assign wbuf_o = '{we: we_q, idx: idx_q, offs: offs_q, data: data_q,
                    be: be_q, ways_hit: ways_hit_q};

  ////////////////////
  // evict buffer
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (armed_i) begin
      evict_adr_q.f <= '{tag: evict_i.tag, idx: evict_i.idx, dat_offs: '0, byte_offs: '0};
      evict_line_q  <= evict_i.line;
    end
  end

  assign evict_o = '{adr: evict_adr_q, line: evict_line_q};

endmodule

`default_nettype wire

// File: src/dcache_recover_timer.sv
// Recover cycle counter for the hit stage.
// Started on the first recover cycle; flags the last one so the
// number of recover cycles is set in one place.

`timescale 1ns/1ns

`include "dcache_settings.svh"

`default_nettype none

module dcache_recover_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  output logic last_o
);

  localparam int CNT_W = $clog2(`DCACHE_RECOVER_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] remaining;

  // cycles left, including the current one
  assign remaining = start_i ? CNT_W'(`DCACHE_RECOVER_CYCLES) : cnt_q;
  assign last_o    = (remaining == CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cnt_q <= '0;
    else if (remaining != '0) cnt_q <= remaining - CNT_W'(1);
  end

endmodule

`default_nettype wire

// File: src/dcache_miss_fsm.sv
// Miss and fill control for the hit stage.
// Issues the way-read and way-write bus commands, tracks the fill, and
// drives stall and memory latch enables for the pipeline.

`timescale 1ns/1ns

`default_nettype none

module dcache_miss_fsm
  import dcache_bus_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    live_i,
  input  logic    served_i,
  input  logic    way_dirty_i,
  input  ways_t   fill_way_i,
  input  logic    biucmd_ack_i,
  input  logic    biucmd_busy_i,
  input  logic    biu_err_i,
  input  logic    recover_last_i,
  output logic    recover_start_o,
  output biucmd_e biucmd_o,
  output logic    armed_o,
  output logic    filling_o,
  output ways_t   fill_way_o,
  output logic    stall_o,
  output logic    latchmem_o
);

  typedef enum logic [1:0] {
    ARMED,
    READ,
    EVICT,
    RECOVER
  } state_e;

  state_e  state_q;
  state_e  state_d;
  biucmd_e biucmd_d;
  logic    miss;
  logic    fill_done;

  // new miss only when the bus interface can take it
  assign miss      = live_i & ~served_i & ~biucmd_busy_i;
  assign fill_done = biucmd_ack_i | biu_err_i;

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d  = state_q;
    biucmd_d = NOP;
    unique case (state_q)
      ARMED: begin
        if (miss) begin
          // new line is read first, the dirty victim written after
          state_d  = way_dirty_i ? EVICT : READ;
          biucmd_d = READWAY;
        end
      end
      READ: begin
        if (fill_done) state_d = RECOVER;
      end
      EVICT: begin
        if (fill_done) begin
          state_d  = RECOVER;
          biucmd_d = WRITEWAY;
        end
      end
      RECOVER: begin
        if (recover_last_i) state_d = ARMED;
      end
      default: state_d = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= ARMED;
      biucmd_o        <= NOP;
      armed_o         <= 1'b1;
      filling_o       <= 1'b0;
      recover_start_o <= 1'b0;
    end else begin
      state_q         <= state_d;
      biucmd_o        <= biucmd_d;
      armed_o         <= (state_d == ARMED);
      filling_o       <= (state_d == READ) | (state_d == EVICT);
      // high on the first recover cycle only
      recover_start_o <= (state_d == RECOVER) & (state_q != RECOVER);
    end
  end

  // fill into the same way the victim came from
  always_ff @(posedge clk_i) begin
    if (state_q == ARMED && miss) fill_way_o <= fill_way_i;
  end

  ////////////////////
  // stall and latch
  ////////////////////

  always_comb begin
    if (state_q == RECOVER) begin
      stall_o    = 1'b1;
      // memories are read again on the final recover cycle
      latchmem_o = recover_last_i;
    end else begin
      stall_o    = live_i & ~served_i;
      latchmem_o = ~stall_o;
    end
  end

endmodule

`default_nettype wire

// File: src/dcache_req_check.sv
// Request qualification for the hit stage.
// Decides whether the incoming request is live and registers the
// exception flags for the downstream stage.

`timescale 1ns/1ns

`default_nettype none

module dcache_req_check
  import dcache_bus_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  core_req_s req_i,
  input  core_exc_s exc_i,
  input  logic      flush_i,
  input  logic      biu_err_i,
  output logic      live_o,
  output logic      err_o,
  output logic      misaligned_o,
  output logic      pagefault_o
);

  logic any_exc;

  assign any_exc = exc_i.misaligned | exc_i.access_fault | exc_i.pagefault;

  // no exception and pipe not flushed
  assign live_o = req_i.req & ~any_exc & ~flush_i;

  ////////////////////
  // exception outputs
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o        <= 1'b0;
      misaligned_o <= 1'b0;
      pagefault_o  <= 1'b0;
    end else begin
      err_o        <= biu_err_i | (req_i.req & exc_i.access_fault);
      misaligned_o <= req_i.req & exc_i.misaligned;
      pagefault_o  <= exc_i.pagefault;
    end
  end

endmodule

`default_nettype wire

// File: src/dcache_bus_pkg.sv
// Bundles exchanged between the hit stage, the core pipeline, the
// tag/data memories and the bus interface, plus the bus command encoding.

`include "dcache_settings.svh"

`default_nettype none

package dcache_bus_pkg;

  import dcache_addr_pkg::*;

  typedef logic [`DCACHE_XLEN-1:0]          word_t;
  typedef logic [`DCACHE_XLEN/8-1:0]        be_t;
  typedef logic [`DCACHE_LINE_BITS/8-1:0]   line_be_t;
  typedef logic [`DCACHE_WAYS-1:0]          ways_t;

  // commands to the bus interface
  typedef enum logic [1:0] {
    NOP      = 2'd0,
    READWAY  = 2'd1,
    WRITEWAY = 2'd2
  } biucmd_e;

  // request from the previous pipeline stage
  typedef struct packed {
    logic        req;
    logic        wreq;
    dcache_adr_u adr;
    be_t         be;
    word_t       d;
  } core_req_s;

  typedef struct packed {
    logic misaligned;
    logic access_fault;
    logic pagefault;
  } core_exc_s;

  // lookup result from tag and data memories
  typedef struct packed {
    logic  hit;
    ways_t ways_hit;
    line_t line;
    logic  way_dirty;
    ways_t fill_way;
  } mem_rsp_s;

  typedef struct packed {
    word_t                   q;
    logic                    ack;
    logic                    err;
    logic [`DCACHE_PLEN-1:0] adro;
  } biu_rsp_s;

  // be is already line aligned
  typedef struct packed {
    logic      we;
    idx_t      idx;
    dat_offs_t offs;
    word_t     data;
    line_be_t  be;
    ways_t     ways_hit;
  } wbuf_s;

  typedef struct packed {
    idx_t  idx;
    tag_t  tag;
    line_t line;
  } evict_in_s;

  typedef struct packed {
    dcache_adr_u adr;
    line_t       line;
  } evict_buf_s;

endpackage

`default_nettype wire

// File: src/dcache_addr_pkg.sv
// Address field types for the data cache.
// A physical address is read either flat or split into tag, set index,
// word offset and byte offset through the union below.

`include "dcache_settings.svh"

`default_nettype none

package dcache_addr_pkg;

  localparam int BYTE_OFFS_BITS = $clog2(`DCACHE_XLEN / 8);
  localparam int DAT_OFFS_BITS  = $clog2(`DCACHE_LINE_BITS / `DCACHE_XLEN);
  localparam int TAG_BITS       = `DCACHE_PLEN - `DCACHE_IDX_BITS - DAT_OFFS_BITS
                                  - BYTE_OFFS_BITS;

  typedef logic [BYTE_OFFS_BITS-1:0]   byte_offs_t;
  typedef logic [DAT_OFFS_BITS-1:0]    dat_offs_t;
  typedef logic [`DCACHE_IDX_BITS-1:0] idx_t;
  typedef logic [TAG_BITS-1:0]         tag_t;

  // msb to lsb, same order as the address bits
  typedef struct packed {
    tag_t       tag;
    idx_t       idx;
    dat_offs_t  dat_offs;
    byte_offs_t byte_offs;
  } dcache_adr_s;

  typedef union packed {
    logic [`DCACHE_PLEN-1:0] flat;
    dcache_adr_s             f;
  } dcache_adr_u;

  typedef logic [`DCACHE_LINE_BITS-1:0] line_t;

endpackage

`default_nettype wire

// File: src/dcache_settings.svh
// Size settings for the data cache hit stage.
// Include this header wherever a width or cycle count is needed.
// The types built from these sizes live in the two packages.

`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

`default_nettype none

// data word and physical address
`define DCACHE_XLEN 32
`define DCACHE_PLEN 32

// line, way and set geometry
`define DCACHE_LINE_BITS 128
`define DCACHE_WAYS 2
`define DCACHE_IDX_BITS 4

// settle time for tag/data memories after a fill
`define DCACHE_RECOVER_CYCLES 2

`default_nettype wire

`endif
